//--- esc_timing_pkg.sv
package esc_timing_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // PWM frame timing
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // The core runs on a 1 MHz clock, so every count below is in microseconds
  localparam int unsigned pwm_period_us = 2500;   // One frame is 2.5 ms, giving a 400 Hz update
  localparam int unsigned min_high_us   = 1000;   // Every ESC pulse is at least 1 ms wide
  localparam int unsigned period_cnt_w  = 12;     // Holds 0 to pwm_period_us minus 1
  localparam int unsigned high_cnt_w    = 10;     // Holds the largest scaled width of 1020

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Shared timebase
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Broadcast from the period timer to the latch and to every pulse block
  typedef struct packed {
    logic                  period_start;  // High for the one cycle where the frame counter is 0
    logic                  high_en;       // High from min_high_us up to the end of the frame
    logic [high_cnt_w-1:0] high_count;    // Cycles spent inside the rate window so far
  } pwm_timebase_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Pulse phase
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Phase of one output pulse within the frame; exported for motor 1 as state_out
  typedef enum logic [2:0] {
    ph_idle      = 3'd0,  // Out of reset, waiting for the first frame
    ph_min_high  = 3'd1,  // Pin high for the fixed minimum time
    ph_rate_high = 3'd2,  // Pin still high while the scaled rate runs out
    ph_low       = 3'd3   // Pin low for the rest of the frame
  } pulse_phase_t;

endpackage

//--- esc_motor_pkg.sv
package esc_motor_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Rate and width sizes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int unsigned rate_w  = 8;           // Raw motor command as it arrives from the core
  localparam int unsigned width_w = rate_w + 2;  // Rate times four needs two extra bits

  // Raw command for one motor, 0 is slowest and 255 is full throttle
  typedef logic [rate_w-1:0] motor_rate_t;

  // Extra high time for one motor in microseconds, always the rate times four
  typedef logic [width_w-1:0] motor_width_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Four-motor bundles
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // All four raw commands, held as plain levels by the flight controller
  typedef struct packed {
    motor_rate_t m1;  // Front left
    motor_rate_t m2;  // Front right
    motor_rate_t m3;  // Rear right
    motor_rate_t m4;  // Rear left
  } motor_rates_t;

  // All four scaled widths, frozen for one whole frame
  typedef struct packed {
    motor_width_t m1;
    motor_width_t m2;
    motor_width_t m3;
    motor_width_t m4;
  } motor_widths_t;

endpackage

//--- rate_latch.sv
`timescale 1ns/100ps

module rate_latch (
  input  logic                          us_clk,
  input  logic                          resetn,
  input  esc_timing_pkg::pwm_timebase_t timebase,  // Only period_start is used here
  input  esc_motor_pkg::motor_rates_t   rates,     // Raw rates, may change at any time
  output esc_motor_pkg::motor_widths_t  widths     // Scaled widths, stable for a frame
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Scaling
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  esc_motor_pkg::motor_widths_t scaled;  // Combinational rate times four for every motor
  esc_motor_pkg::motor_widths_t widths_q;  // Frame-held copy of scaled

  // A shift by two keeps each step of the raw rate at exactly 4 us of pulse
  always_comb begin
    scaled.m1 = {rates.m1, 2'b00};  // Motor 1 rate times four
    scaled.m2 = {rates.m2, 2'b00};  // Motor 2 rate times four
    scaled.m3 = {rates.m3, 2'b00};  // Motor 3 rate times four
    scaled.m4 = {rates.m4, 2'b00};  // Motor 4 rate times four
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Frame latch
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // All four motors reload on the same edge so a new command set
  // takes effect on one frame boundary and never mid-pulse
  always_ff @(posedge us_clk or negedge resetn) begin
    if (!resetn) begin
      widths_q <= '0;  // Minimum pulse only until the first frame has latched
    end else if (timebase.period_start) begin
      widths_q.m1 <= scaled.m1;  // Captured at the frame boundary
      widths_q.m2 <= scaled.m2;
      widths_q.m3 <= scaled.m3;
      widths_q.m4 <= scaled.m4;
    end
  end

  // Registered widths go straight out to the pulse blocks
  assign widths = widths_q;

endmodule

//--- pwm_period_timer.sv
`timescale 1ns/100ps

module pwm_period_timer (
  input  logic                          us_clk,
  input  logic                          resetn,
  output esc_timing_pkg::pwm_timebase_t timebase  // Frame timing shared by all motors
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Frame counter
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  logic [esc_timing_pkg::period_cnt_w-1:0] period_cnt;       // Position in the frame, 0 to 2499
  logic [esc_timing_pkg::period_cnt_w-1:0] period_cnt_next;  // Value loaded on the next edge
  logic                                    period_wrap;      // Last cycle of the frame
  logic                                    window_open;      // Next cycle starts the rate window

  logic                                  high_en;     // Rate window is open
  logic [esc_timing_pkg::high_cnt_w-1:0] high_count;  // Cycles since the window opened

  // This is the only place that looks at the absolute frame position
  assign period_wrap = (period_cnt ==
                        esc_timing_pkg::period_cnt_w'(esc_timing_pkg::pwm_period_us - 1));

  assign period_cnt_next = period_wrap ? '0 : period_cnt + 1'b1;  // Free-running modulo count

  // Decoded on the next count so the flag is already set while the count sits at min_high_us
  assign window_open = (period_cnt_next ==
                        esc_timing_pkg::period_cnt_w'(esc_timing_pkg::min_high_us));

  // Reset parks the counter on the last count, so the first edge
  // after release lands on 0 and starts a frame straight away
  always_ff @(posedge us_clk or negedge resetn) begin
    if (!resetn) begin
      period_cnt <= esc_timing_pkg::period_cnt_w'(esc_timing_pkg::pwm_period_us - 1);
    end else begin
      period_cnt <= period_cnt_next;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Rate window
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // The window runs from min_high_us to the end of the frame
  always_ff @(posedge us_clk or negedge resetn) begin
    if (!resetn) begin
      high_en <= 1'b0;
    end else if (period_wrap) begin
      high_en <= 1'b0;  // Closed at every frame boundary
    end else if (window_open) begin
      high_en <= 1'b1;  // Minimum high time has elapsed
    end
  end

  // Counts the extra high time; the pulse blocks compare it to their width
  always_ff @(posedge us_clk or negedge resetn) begin
    if (!resetn) begin
      high_count <= '0;
    end else if (period_wrap) begin
      high_count <= '0;  // Every frame starts from zero
    end else if (high_en) begin
      high_count <= high_count + 1'b1;  // May roll over late in the frame, after every pulse fell
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Timebase out
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    timebase.period_start = (period_cnt == '0);  // One cycle per frame
    timebase.high_en      = high_en;
    timebase.high_count   = high_count;
  end

endmodule

//--- pwm_pulse_block.sv
`timescale 1ns/100ps

module pwm_pulse_block (
  input  logic                          us_clk,
  input  logic                          resetn,
  input  esc_timing_pkg::pwm_timebase_t timebase,   // Shared frame timing
  input  esc_motor_pkg::motor_width_t   width,      // Extra high time for this motor
  output logic                          motor_pwm,  // Pin to the ESC
  output esc_timing_pkg::pulse_phase_t  phase       // Current pulse phase
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Phase FSM
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  esc_timing_pkg::pulse_phase_t phase_q;  // Current phase
  esc_timing_pkg::pulse_phase_t phase_d;  // Phase after the next edge
  logic                         width_done;  // Rate part of the pulse has run out
  logic                         pin_high_d;  // Pin level after the next edge
  logic                         pwm_q;       // Registered pin, free of decode glitches

  // Both sides are 10 bits wide; this is the only width comparison in the design
  assign width_done = (timebase.high_count >= width);

  // A frame start always restarts the pulse, whatever phase the block is in
  always_comb begin
    phase_d = phase_q;
    if (timebase.period_start) begin
      phase_d = esc_timing_pkg::ph_min_high;  // Rising edge of the pulse
    end else begin
      case (phase_q)
        esc_timing_pkg::ph_min_high: begin
          if (timebase.high_en) begin
            // A zero width ends the pulse right at the minimum time
            if (width_done) begin
              phase_d = esc_timing_pkg::ph_low;
            end else begin
              phase_d = esc_timing_pkg::ph_rate_high;
            end
          end
        end
        esc_timing_pkg::ph_rate_high: begin
          if (width_done) begin
            phase_d = esc_timing_pkg::ph_low;  // Falling edge of the pulse
          end
        end
        default: begin
          phase_d = phase_q;  // Idle and low both wait for the next frame
        end
      endcase
    end
  end

  // Pin is high only in the two high phases
  assign pin_high_d = (phase_d == esc_timing_pkg::ph_min_high) ||
                      (phase_d == esc_timing_pkg::ph_rate_high);

  always_ff @(posedge us_clk or negedge resetn) begin
    if (!resetn) begin
      phase_q <= esc_timing_pkg::ph_idle;  // No pulse until the first frame starts
      pwm_q   <= 1'b0;                     // ESC sees a low line during reset
    end else begin
      phase_q <= phase_d;
      pwm_q   <= pin_high_d;  // Pin and phase always change on the same edge
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Outputs
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign motor_pwm = pwm_q;
  assign phase     = phase_q;

endmodule

//--- esc_pwm.sv
`timescale 1ns/100ps

module esc_pwm (
  input  logic                         us_clk,     // 1 MHz, one cycle per microsecond
  input  logic                         resetn,
  input  esc_motor_pkg::motor_rates_t  rates,      // Raw rates as levels, no strobe
  output logic [3:0]                   motor_pwm,  // Bit 0 drives motor 1
  output esc_timing_pkg::pulse_phase_t state_out   // Pulse phase of motor 1
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Internal wiring
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  esc_timing_pkg::pwm_timebase_t timebase;  // Frame timing from the timer
  esc_motor_pkg::motor_widths_t  widths;    // Frame-held widths from the latch

  // Frame timebase shared by the latch and all four pulse blocks
  pwm_period_timer u_period_timer (
    .us_clk   (us_clk),
    .resetn   (resetn),
    .timebase (timebase)
  );

  // Captures the four rates once per frame
  rate_latch u_rate_latch (
    .us_clk   (us_clk),
    .resetn   (resetn),
    .timebase (timebase),
    .rates    (rates),
    .widths   (widths)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Pulse blocks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Motor 1 also reports its phase at the top level
  pwm_pulse_block u_pulse_m1 (
    .us_clk    (us_clk),
    .resetn    (resetn),
    .timebase  (timebase),
    .width     (widths.m1),
    .motor_pwm (motor_pwm[0]),
    .phase     (state_out)
  );

  pwm_pulse_block u_pulse_m2 (
    .us_clk    (us_clk),
    .resetn    (resetn),
    .timebase  (timebase),
    .width     (widths.m2),
    .motor_pwm (motor_pwm[1]),
    .phase     ()  // Not exported
  );

  pwm_pulse_block u_pulse_m3 (
    .us_clk    (us_clk),
    .resetn    (resetn),
    .timebase  (timebase),
    .width     (widths.m3),
    .motor_pwm (motor_pwm[2]),
    .phase     ()  // Not exported
  );

  pwm_pulse_block u_pulse_m4 (
    .us_clk    (us_clk),
    .resetn    (resetn),
    .timebase  (timebase),
    .width     (widths.m4),
    .motor_pwm (motor_pwm[3]),
    .phase     ()  // Not exported
  );

endmodule

//--- tb_esc_pwm.sv
`timescale 1ns/100ps

module tb_esc_pwm;

  localparam int n_periods   = 23;    // Two fixed frames, one latching frame, twenty random
  localparam int wait_limit  = 3000;  // Longest wait for any pin edge, in clock cycles

  logic                         us_clk;
  logic                         resetn;
  esc_motor_pkg::motor_rates_t  rates;      // Driven on the falling edge only
  logic [3:0]                   motor_pwm;
  esc_timing_pkg::pulse_phase_t state_out;

  int unsigned cycle;        // Rising clock edges seen so far
  int unsigned release_cyc;  // Edge count when resetn went high
  integer      seed;
  int          rise_at [4][n_periods];  // Edge count at each rising edge per motor
  int          high_at [4][n_periods];  // Measured high time per motor and frame

  esc_pwm u_esc_pwm (
    .us_clk    (us_clk),
    .resetn    (resetn),
    .rates     (rates),
    .motor_pwm (motor_pwm),
    .state_out (state_out)
  );

  always #2 us_clk = ~us_clk;  // 4 ns period

  always @(posedge us_clk) cycle <= cycle + 1;  // Free-running edge counter

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Reference and compare
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Pulse is the fixed minimum plus four microseconds per rate step
  function automatic int expected_high(input int rate);
    return esc_timing_pkg::min_high_us + 4 * rate;
  endfunction

  function automatic int rate_of(input int m);
    case (m)
      0:       return rates.m1;
      1:       return rates.m2;
      2:       return rates.m3;
      default: return rates.m4;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("Error at %0t ns: %s is %0d, expected %0d", $time, name, actual, expected);
      $display("Result: FAILED");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  // Samples 1 ns after each rising edge, where outputs have settled and inputs are still stable
  task automatic wait_level(input int m, input logic level);
    int n;
    n = 0;
    @(posedge us_clk);
    #1;
    while (motor_pwm[m] !== level) begin
      if (n >= wait_limit) begin
        $display("Timeout: motor %0d never toggled to %0d within %0d cycles", m + 1, level,
                 wait_limit);
        $display("Result: FAILED");
        $fatal(1, "Pin edge never came");
      end
      n++;
      @(posedge us_clk);
      #1;
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Checkers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // One per motor; measures every frame against the rate seen at its rising edge
  task automatic watch_motor(input int m);
    int rec_rate;
    int rise_cyc;
    for (int p = 0; p < n_periods; p++) begin
      wait_level(m, 1'b1);
      rise_cyc = cycle;
      rec_rate = rate_of(m);  // Value the latch captured on this same edge
      if (p == 0) begin
        check_value($sformatf("motor %0d first rise delay", m + 1), rise_cyc - release_cyc, 2);
      end else begin
        check_value($sformatf("motor %0d period", m + 1), rise_cyc - rise_at[m][p-1],
                    esc_timing_pkg::pwm_period_us);
      end
      rise_at[m][p] = rise_cyc;
      wait_level(m, 1'b0);
      high_at[m][p] = cycle - rise_cyc;
      check_value($sformatf("motor %0d high time", m + 1), high_at[m][p],
                  expected_high(rec_rate));
    end
  endtask

  // Follows state_out cycle by cycle against the level of motor pin 1
  task automatic watch_phase(input int n_cycles);
    int  hi_cnt;
    logic seen_rise;
    hi_cnt    = 0;
    seen_rise = 1'b0;
    repeat (n_cycles) begin
      @(posedge us_clk);
      #1;
      if (motor_pwm[0]) begin
        seen_rise = 1'b1;
        if (hi_cnt < esc_timing_pkg::min_high_us)
          check_value("state_out", state_out, esc_timing_pkg::ph_min_high);
        else
          check_value("state_out", state_out, esc_timing_pkg::ph_rate_high);
        hi_cnt++;
      end else begin
        hi_cnt = 0;
        if (seen_rise)
          check_value("state_out", state_out, esc_timing_pkg::ph_low);
        else
          check_value("state_out", state_out, esc_timing_pkg::ph_idle);  // Before first frame
      end
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stimulus
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic drive_rates();
    int delay;
    wait_level(0, 1'b1);  // Frame 0
    wait_level(0, 1'b0);
    wait_level(0, 1'b1);  // Frame 1
    repeat (500) @(negedge us_clk);
    rates = '{m1: 8'd200, m2: 8'd10, m3: 8'd77, m4: 8'd255};  // Mid-pulse change
    for (int i = 0; i < 20; i++) begin
      wait_level(0, 1'b0);
      wait_level(0, 1'b1);
      delay = 1 + ($unsigned($random(seed)) % 2000);  // Anywhere in the frame
      repeat (delay) @(negedge us_clk);
      rates = esc_motor_pkg::motor_rates_t'($random(seed));
    end
  endtask

  initial begin
    us_clk      = 1'b0;
    resetn      = 1'b0;
    cycle       = 0;
    seed        = 32'h27fa_6017;
    rates = '{m1: 8'd0, m2: 8'd255, m3: 8'd128, m4: 8'd64};  // Frame 0 corner rates
    repeat (3) begin
      @(negedge us_clk);
      check_value("motor_pwm in reset", motor_pwm, 4'b0000);
      check_value("state_out in reset", state_out, esc_timing_pkg::ph_idle);
    end
    resetn      = 1'b1;  // Released on a falling edge
    release_cyc = cycle;
    fork
      watch_motor(0);
      watch_motor(1);
      watch_motor(2);
      watch_motor(3);
      watch_phase(n_periods * esc_timing_pkg::pwm_period_us);
      drive_rates();
    join
    // All four pins start every frame on the same edge
    for (int p = 0; p < n_periods; p++)
      for (int m = 1; m < 4; m++)
        check_value($sformatf("motor %0d rise edge", m + 1), rise_at[m][p], rise_at[0][p]);
    check_value("motor 1 width at rate 0", high_at[0][0], 1000);
    check_value("motor 2 width at rate 255", high_at[1][0], 2020);
    check_value("motor 3 width at rate 128", high_at[2][0], 1512);
    check_value("motor 1 width in changed frame", high_at[0][1], 1000);  // Old rate held
    check_value("motor 2 width in changed frame", high_at[1][1], 2020);
    check_value("motor 1 width after change", high_at[0][2], expected_high(200));
    check_value("motor 4 width after change", high_at[3][2], expected_high(255));
    $display("Result: PASSED");
    $finish;
  end

endmodule

//--- esc_pwm.f
esc_timing_pkg.sv
esc_motor_pkg.sv
rate_latch.sv
pwm_period_timer.sv
pwm_pulse_block.sv
esc_pwm.sv
tb_esc_pwm.sv
